/* verilog/poker_pkg.sv */
`default_nettype none

package poker_pkg;

    // Width of every chip quantity in the design
    localparam int STACK_W = 11;

    // Unsigned chip count
    typedef logic [STACK_W-1:0] chips_t;

    // Streets of one hand
    typedef enum logic [3:0] {
        idle,
        pre_flop,
        flop,
        turn,
        river,
        showdown
    } hand_state_t;

    // Betting progress within one street
    typedef enum logic [3:0] {
        start_betting,
        bb_ready,
        bb_play,
        sb_ready,
        sb_play,
        sb_win,
        bb_win,
        next
    } bet_stage_t;

endpackage

`default_nettype wire

/* verilog/chip_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface chip_bus_if;

    import poker_pkg::*;

    // One-cycle command pulse from the table
    logic en;
    logic make_bet;
    logic add_profit;
    chips_t amount;

    // Current stack held by the bank
    chips_t stack;

    modport table_side (
        output en,
        output make_bet,
        output add_profit,
        output amount,
        input  stack
    );

    modport bank (
        input  en,
        input  make_bet,
        input  add_profit,
        input  amount,
        output stack
    );

endinterface

`default_nettype wire

/* verilog/player_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module player_bank #(
    parameter poker_pkg::chips_t START_STACK = 200
) (
    input logic clk,
    input logic reset,
    chip_bus_if.bank bus
);

    // Bets and winnings land on the edge closing the pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            bus.stack <= START_STACK;
        end else if (bus.en) begin
            if (bus.make_bet) begin
                bus.stack <= bus.stack - bus.amount;
            end else if (bus.add_profit) begin
                bus.stack <= bus.stack + bus.amount;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/street_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module street_sequencer (
    input logic clk,
    input logic reset,
    input logic advance,
    input logic round_done,
    input logic stack_empty,
    output poker_pkg::hand_state_t state,
    output logic small_blind
);

    import poker_pkg::*;

    hand_state_t next_state;

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (advance) begin
                    next_state = pre_flop;
                end
            end
            pre_flop: begin
                if (round_done) begin
                    next_state = stack_empty ? showdown : flop;
                end
            end
            flop: begin
                if (round_done) begin
                    next_state = stack_empty ? showdown : turn;
                end
            end
            turn: begin
                if (round_done) begin
                    next_state = stack_empty ? showdown : river;
                end
            end
            river: begin
                if (round_done) begin
                    next_state = showdown;
                end
            end
            showdown: begin
                if (advance) begin
                    next_state = pre_flop;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // Button passes to the other player for the next hand
    always_ff @(posedge clk) begin
        if (reset) begin
            small_blind <= 1'b0;
        end else if (state == showdown && advance) begin
            small_blind <= ~small_blind;
        end
    end

endmodule

`default_nettype wire

/* verilog/betting_round.sv */
`timescale 1ns/1ns
`default_nettype none

module betting_round #(
    parameter poker_pkg::chips_t SB_SIZE = 1,
    parameter poker_pkg::chips_t BB_SIZE = 2
) (
    input logic clk,
    input logic reset,
    input logic advance,
    input logic check_or_call,
    input logic bet_or_raise,
    input logic fold,
    input poker_pkg::chips_t bet_input,
    input poker_pkg::hand_state_t state,
    input logic small_blind,
    input logic showdown_winner,
    input logic showdown_draw,
    output poker_pkg::chips_t pot,
    output poker_pkg::chips_t min_bet_or_raise,
    output poker_pkg::chips_t call_size,
    output logic call_or_raise,
    output logic current_player,
    output logic wait_screen,
    output logic adv_ready,
    output logic play_ready,
    output logic round_done,
    output logic stack_empty,
    chip_bus_if.table_side p1,
    chip_bus_if.table_side p2
);

    import poker_pkg::*;

    bet_stage_t stage;
    chips_t sb_invested;
    chips_t bb_invested;
    chips_t actor_invested;
    chips_t other_invested;
    chips_t bet_size;
    chips_t bb_stack;
    logic sb_turn;
    logic sb_en;
    logic bb_en;
    logic make_bet;
    logic add_profit;
    logic both_played;
    logic paid;
    logic cmd_p2_sb;

    // Stack value once a command still on the bus has landed
    function automatic chips_t settled_stack(
        input chips_t stack,
        input logic en,
        input logic bet,
        input logic profit,
        input chips_t amount
    );
        chips_t result;
        result = stack;
        if (en && bet) begin
            result = stack - amount;
        end else if (en && profit) begin
            result = stack + amount;
        end
        return result;
    endfunction

    assign sb_turn = (stage == sb_ready) || (stage == sb_play);
    assign actor_invested = sb_turn ? sb_invested : bb_invested;
    assign other_invested = sb_turn ? bb_invested : sb_invested;
    assign call_size = other_invested - actor_invested;

    // small_blind high means player 2 holds the small blind
    assign current_player = small_blind ? sb_turn : ~sb_turn;
    assign bb_stack = small_blind ? p1.stack : p2.stack;

    assign wait_screen = (stage == sb_ready) || (stage == bb_ready);
    assign play_ready = (stage == sb_play) || (stage == bb_play);
    assign adv_ready = (state == idle) || (state == showdown) || wait_screen;
    assign round_done = (stage == next);

    assign stack_empty =
        (settled_stack(p1.stack, p1.en, p1.make_bet, p1.add_profit, p1.amount) == '0) ||
        (settled_stack(p2.stack, p2.en, p2.make_bet, p2.add_profit, p2.amount) == '0);

    // Roles mapped with the button as it stood when the command was issued
    assign p1.en = cmd_p2_sb ? bb_en : sb_en;
    assign p2.en = cmd_p2_sb ? sb_en : bb_en;
    assign p1.make_bet = make_bet;
    assign p2.make_bet = make_bet;
    assign p1.add_profit = add_profit;
    assign p2.add_profit = add_profit;
    assign p1.amount = bet_size;
    assign p2.amount = bet_size;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= start_betting;
            pot <= '0;
            min_bet_or_raise <= BB_SIZE;
            call_or_raise <= 1'b0;
            sb_invested <= '0;
            bb_invested <= '0;
            bet_size <= '0;
            sb_en <= 1'b0;
            bb_en <= 1'b0;
            make_bet <= 1'b0;
            add_profit <= 1'b0;
            both_played <= 1'b0;
            paid <= 1'b0;
            cmd_p2_sb <= 1'b0;
        end else begin
            sb_en <= 1'b0;
            bb_en <= 1'b0;
            make_bet <= 1'b0;
            add_profit <= 1'b0;
            cmd_p2_sb <= small_blind;
            if (state != showdown) begin
                paid <= 1'b0;
            end
            case (state)
                pre_flop, flop, turn, river: begin
                    case (stage)
                        start_betting: begin
                            min_bet_or_raise <= BB_SIZE;
                            if (state == pre_flop) begin
                                call_or_raise <= 1'b1;
                                // Blinds go in one per cycle
                                if (sb_invested == '0) begin
                                    sb_invested <= SB_SIZE;
                                    bet_size <= SB_SIZE;
                                    sb_en <= 1'b1;
                                    make_bet <= 1'b1;
                                    pot <= pot + SB_SIZE;
                                end else if (bb_invested == '0) begin
                                    bb_invested <= BB_SIZE;
                                    bet_size <= BB_SIZE;
                                    bb_en <= 1'b1;
                                    make_bet <= 1'b1;
                                    pot <= pot + BB_SIZE;
                                end else begin
                                    stage <= sb_ready;
                                end
                            end else begin
                                call_or_raise <= 1'b0;
                                sb_invested <= '0;
                                bb_invested <= '0;
                                both_played <= 1'b0;
                                stage <= (bb_stack != '0) ? bb_ready : sb_ready;
                            end
                        end
                        sb_ready, bb_ready: begin
                            if (advance) begin
                                stage <= sb_turn ? sb_play : bb_play;
                            end
                        end
                        sb_play, bb_play: begin
                            if (advance) begin
                                both_played <= 1'b1;
                                if (fold) begin
                                    stage <= sb_turn ? bb_win : sb_win;
                                end else if (check_or_call) begin
                                    bet_size <= call_size;
                                    pot <= pot + call_size;
                                    make_bet <= 1'b1;
                                    sb_en <= sb_turn;
                                    bb_en <= ~sb_turn;
                                    if (sb_turn) begin
                                        sb_invested <= bb_invested;
                                    end else begin
                                        bb_invested <= sb_invested;
                                    end
                                    call_or_raise <= 1'b0;
                                    if (both_played) begin
                                        stage <= next;
                                    end else begin
                                        stage <= sb_turn ? bb_ready : sb_ready;
                                    end
                                end else if (bet_or_raise) begin
                                    // bet_input is the amount above the call
                                    bet_size <= call_size + bet_input;
                                    pot <= pot + call_size + bet_input;
                                    make_bet <= 1'b1;
                                    sb_en <= sb_turn;
                                    bb_en <= ~sb_turn;
                                    if (sb_turn) begin
                                        sb_invested <= other_invested + bet_input;
                                    end else begin
                                        bb_invested <= other_invested + bet_input;
                                    end
                                    min_bet_or_raise <= other_invested + bet_input;
                                    call_or_raise <= 1'b1;
                                    stage <= sb_turn ? bb_ready : sb_ready;
                                end
                            end
                        end
                        sb_win, bb_win: begin
                            sb_en <= (stage == sb_win);
                            bb_en <= (stage == bb_win);
                            add_profit <= 1'b1;
                            bet_size <= pot;
                            pot <= '0;
                            stage <= next;
                        end
                        default: begin
                            stage <= start_betting;
                        end
                    endcase
                end
                default: begin
                    // Idle or showdown, ready the table for a fresh hand
                    stage <= start_betting;
                    sb_invested <= '0;
                    bb_invested <= '0;
                    both_played <= 1'b0;
                    call_or_raise <= 1'b0;
                    min_bet_or_raise <= BB_SIZE;
                    if (state == showdown && !paid) begin
                        paid <= 1'b1;
                        add_profit <= 1'b1;
                        pot <= '0;
                        if (showdown_draw) begin
                            // Odd chip is lost
                            bet_size <= pot >> 1;
                            sb_en <= 1'b1;
                            bb_en <= 1'b1;
                        end else begin
                            bet_size <= pot;
                            sb_en <= (showdown_winner == small_blind);
                            bb_en <= (showdown_winner != small_blind);
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/poker_hand_top.sv */
`timescale 1ns/1ns
`default_nettype none

module poker_hand_top #(
    parameter poker_pkg::chips_t SB_SIZE = 1,
    parameter poker_pkg::chips_t BB_SIZE = 2,
    parameter poker_pkg::chips_t START_STACK = 200
) (
    input logic clk,
    input logic reset,
    input logic advance,
    input logic check_or_call,
    input logic bet_or_raise,
    input logic fold,
    input poker_pkg::chips_t bet_input,
    input logic showdown_winner,
    input logic showdown_draw,
    output logic small_blind,
    output poker_pkg::chips_t current_pot,
    output poker_pkg::chips_t min_bet_or_raise,
    output poker_pkg::chips_t call_size,
    output poker_pkg::hand_state_t curr_state,
    output logic call_or_raise,
    output logic current_player,
    output logic wait_screen,
    output logic adv_ready,
    output logic play_ready,
    output poker_pkg::chips_t player1_stack,
    output poker_pkg::chips_t player2_stack
);

    logic round_done;
    logic stack_empty;

    chip_bus_if p1_bus ();
    chip_bus_if p2_bus ();

    street_sequencer sequencer (
        .clk        (clk),
        .reset      (reset),
        .advance    (advance),
        .round_done (round_done),
        .stack_empty(stack_empty),
        .state      (curr_state),
        .small_blind(small_blind)
    );

    betting_round #(
        .SB_SIZE(SB_SIZE),
        .BB_SIZE(BB_SIZE)
    ) betting (
        .clk             (clk),
        .reset           (reset),
        .advance         (advance),
        .check_or_call   (check_or_call),
        .bet_or_raise    (bet_or_raise),
        .fold            (fold),
        .bet_input       (bet_input),
        .state           (curr_state),
        .small_blind     (small_blind),
        .showdown_winner (showdown_winner),
        .showdown_draw   (showdown_draw),
        .pot             (current_pot),
        .min_bet_or_raise(min_bet_or_raise),
        .call_size       (call_size),
        .call_or_raise   (call_or_raise),
        .current_player  (current_player),
        .wait_screen     (wait_screen),
        .adv_ready       (adv_ready),
        .play_ready      (play_ready),
        .round_done      (round_done),
        .stack_empty     (stack_empty),
        .p1              (p1_bus.table_side),
        .p2              (p2_bus.table_side)
    );

    player_bank #(
        .START_STACK(START_STACK)
    ) bank1 (
        .clk  (clk),
        .reset(reset),
        .bus  (p1_bus.bank)
    );

    player_bank #(
        .START_STACK(START_STACK)
    ) bank2 (
        .clk  (clk),
        .reset(reset),
        .bus  (p2_bus.bank)
    );

    assign player1_stack = p1_bus.stack;
    assign player2_stack = p2_bus.stack;

endmodule

`default_nettype wire

/* sim/tb_poker_hand.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_poker_hand;

    import poker_pkg::*;

    localparam chips_t SB_SIZE = 1;
    localparam chips_t BB_SIZE = 2;
    localparam chips_t START_STACK = 200;
    localparam int clk_period = 4;
    // Five hands after reset, each far below this many cycles
    localparam int hand_count = 5;
    localparam int cycles_per_hand = 1000;
    localparam int timeout_ns = hand_count * cycles_per_hand * clk_period;

    typedef enum {do_call, do_raise, do_fold} action_t;

    logic clk;
    logic reset;
    logic advance;
    logic check_or_call;
    logic bet_or_raise;
    logic fold;
    chips_t bet_input;
    logic showdown_winner;
    logic showdown_draw;
    logic small_blind;
    chips_t current_pot;
    chips_t min_bet_or_raise;
    chips_t call_size;
    hand_state_t curr_state;
    logic call_or_raise;
    logic current_player;
    logic wait_screen;
    logic adv_ready;
    logic play_ready;
    chips_t player1_stack;
    chips_t player2_stack;

    // Reference model of the table with player 1 at index 0
    chips_t exp_stack [2];
    chips_t exp_pot;
    chips_t inv_sb;
    chips_t inv_bb;
    chips_t exp_min;
    logic exp_cor;
    logic button;
    int exp_total;
    int errors;
    int flop_cycles = 0;

    poker_hand_top dut0 (.*);

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        if (curr_state == flop) begin
            flop_cycles <= flop_cycles + 1;
        end
    end

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic check_table();
        compare("current_pot", current_pot, exp_pot);
        compare("player1_stack", player1_stack, exp_stack[0]);
        compare("player2_stack", player2_stack, exp_stack[1]);
        compare("chip_total", 32'(player1_stack) + 32'(player2_stack) + 32'(current_pot),
                exp_total);
    endtask

    task automatic pay(input logic who, input chips_t amount);
        exp_stack[who] -= amount;
        exp_pot += amount;
    endtask

    task automatic drive_advance(input logic c, input logic b, input logic f,
                                 input chips_t amount);
        @(posedge clk);
        advance <= 1'b1;
        check_or_call <= c;
        bet_or_raise <= b;
        fold <= f;
        bet_input <= amount;
        @(posedge clk);
        advance <= 1'b0;
        check_or_call <= 1'b0;
        bet_or_raise <= 1'b0;
        fold <= 1'b0;
        bet_input <= '0;
    endtask

    // Only used inside a street, where readiness means a ready stage
    task automatic advance_when_ready();
        do @(negedge clk); while (!adv_ready);
        compare("wait_screen", wait_screen, 1'b1);
        drive_advance(1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic set_showdown(input logic winner, input logic draw);
        @(posedge clk);
        showdown_winner <= winner;
        showdown_draw <= draw;
    endtask

    // Waits for the play stage, checks the table, then acts
    task automatic act(input logic actor_sb, input action_t action, input chips_t amount);
        chips_t mine;
        chips_t other;
        logic who;
        do @(negedge clk); while (!play_ready);
        mine = actor_sb ? inv_sb : inv_bb;
        other = actor_sb ? inv_bb : inv_sb;
        who = actor_sb ? button : !button;
        check_table();
        compare("current_player", current_player, who);
        compare("call_size", call_size, other - mine);
        compare("min_bet_or_raise", min_bet_or_raise, exp_min);
        compare("call_or_raise", call_or_raise, exp_cor);
        case (action)
            do_call: begin
                pay(who, other - mine);
                mine = other;
                exp_cor = 1'b0;
            end
            do_raise: begin
                pay(who, other - mine + amount);
                mine = other + amount;
                exp_min = mine;
                exp_cor = 1'b1;
            end
            default: begin
                exp_stack[!who] += exp_pot;
                exp_pot = '0;
            end
        endcase
        if (actor_sb) begin
            inv_sb = mine;
        end else begin
            inv_bb = mine;
        end
        drive_advance(action == do_call, action == do_raise, action == do_fold, amount);
    endtask

    task automatic take_turn(input logic actor_sb, input action_t action, input chips_t amount);
        advance_when_ready();
        act(actor_sb, action, amount);
    endtask

    task automatic start_hand();
        logic from_showdown;
        do @(negedge clk); while (!adv_ready);
        from_showdown = (curr_state == showdown);
        drive_advance(1'b0, 1'b0, 1'b0, '0);
        if (from_showdown) begin
            button = !button;
        end
        @(negedge clk);
        compare("curr_state", curr_state, pre_flop);
        compare("small_blind", small_blind, button);
        pay(button, SB_SIZE);
        pay(!button, BB_SIZE);
        inv_sb = SB_SIZE;
        inv_bb = BB_SIZE;
        exp_min = BB_SIZE;
        exp_cor = 1'b1;
    endtask

    task automatic next_street(input hand_state_t expected);
        hand_state_t from;
        @(negedge clk);
        from = curr_state;
        while (curr_state == from) @(negedge clk);
        compare("curr_state", curr_state, expected);
        inv_sb = '0;
        inv_bb = '0;
        exp_min = BB_SIZE;
        exp_cor = 1'b0;
    endtask

    // Big blind speaks first after the flop
    task automatic check_through(input hand_state_t following);
        take_turn(1'b0, do_call, '0);
        take_turn(1'b1, do_call, '0);
        next_street(following);
    endtask

    // Payout lands two cycles after showdown is entered
    task automatic settle_showdown(input logic winner, input logic draw);
        repeat (2) @(negedge clk);
        if (draw) begin
            exp_total -= exp_pot % 2;
            exp_stack[0] += exp_pot >> 1;
            exp_stack[1] += exp_pot >> 1;
        end else begin
            exp_stack[winner] += exp_pot;
        end
        exp_pot = '0;
        check_table();
    endtask

    task automatic test_reset();
        @(negedge clk);
        compare("curr_state", curr_state, idle);
        compare("adv_ready", adv_ready, 1'b1);
        compare("play_ready", play_ready, 1'b0);
        compare("wait_screen", wait_screen, 1'b0);
        compare("small_blind", small_blind, 1'b0);
        check_table();
    endtask

    task automatic test_preflop_fold();
        start_hand();
        advance_when_ready();
        act(1'b1, do_fold, '0);
        next_street(flop);
        check_table();
        set_showdown(1'b0, 1'b0);
        check_through(turn);
        check_through(river);
        check_through(showdown);
        settle_showdown(1'b0, 1'b0);
    endtask

    task automatic test_calls_to_showdown();
        start_hand();
        take_turn(1'b1, do_call, '0);
        take_turn(1'b0, do_call, '0);
        next_street(flop);
        set_showdown(1'b1, 1'b0);
        check_through(turn);
        check_through(river);
        check_through(showdown);
        settle_showdown(1'b1, 1'b0);
    endtask

    task automatic test_raises();
        chips_t raise1;
        chips_t raise2;
        raise1 = chips_t'($urandom_range(20, 1));
        raise2 = chips_t'($urandom_range(20, 1));
        start_hand();
        take_turn(1'b1, do_raise, raise1);
        take_turn(1'b0, do_raise, raise2);
        take_turn(1'b1, do_call, '0);
        next_street(flop);
        set_showdown(1'b0, 1'b0);
        check_through(turn);
        check_through(river);
        check_through(showdown);
        settle_showdown(1'b0, 1'b0);
    endtask

    task automatic test_draw();
        start_hand();
        take_turn(1'b1, do_call, '0);
        take_turn(1'b0, do_call, '0);
        next_street(flop);
        take_turn(1'b0, do_raise, 5);
        take_turn(1'b1, do_call, '0);
        next_street(turn);
        set_showdown(1'b0, 1'b1);
        check_through(river);
        check_through(showdown);
        settle_showdown(1'b0, 1'b1);
    endtask

    task automatic test_all_in();
        int flops_before;
        chips_t shove;
        chips_t room;
        set_showdown(1'b1, 1'b0);
        flops_before = flop_cycles;
        start_hand();
        // Shove what the shorter stack can cover
        room = exp_stack[button] - (inv_bb - inv_sb);
        shove = (room < exp_stack[!button]) ? room : exp_stack[!button];
        take_turn(1'b1, do_raise, shove);
        take_turn(1'b0, do_call, '0);
        next_street(showdown);
        settle_showdown(1'b1, 1'b0);
        compare("flop_cycles", flop_cycles, flops_before);
    endtask

    initial begin
        void'($urandom(32'h9e44_f9fc));
        errors = 0;
        reset = 1'b1;
        advance = 1'b0;
        check_or_call = 1'b0;
        bet_or_raise = 1'b0;
        fold = 1'b0;
        bet_input = '0;
        showdown_winner = 1'b0;
        showdown_draw = 1'b0;
        exp_stack[0] = START_STACK;
        exp_stack[1] = START_STACK;
        exp_pot = '0;
        inv_sb = '0;
        inv_bb = '0;
        exp_min = BB_SIZE;
        exp_cor = 1'b0;
        button = 1'b0;
        exp_total = 2 * START_STACK;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_preflop_fold();
        test_calls_to_showdown();
        test_raises();
        test_draw();
        test_all_in();
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout after %0d ns, the tests never finished (%0d errors so far)",
                 timeout_ns, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/poker_pkg.sv
verilog/chip_bus_if.sv
verilog/player_bank.sv
verilog/street_sequencer.sv
verilog/betting_round.sv
verilog/poker_hand_top.sv
sim/tb_poker_hand.sv

/* Makefile */
TOOL       := verilator
TOP        := tb_poker_hand
LINT_TOP   := poker_hand_top
FILELIST   := project.f
FLAGS      := --binary --timing -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(LINT_TOP)
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
